//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ADC display testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_adc_display
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module tb_adc_display \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG_FILE"; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL"
    exit 1
fi

//--- sim.f
source/adc_display_pkg.sv
source/drp_reader.sv
source/display_control.sv
source/bin_to_bcd.sv
source/seg_scan.sv
source/adc_display_top.sv
testbench/adc_drp_model.sv
testbench/tb_adc_display.sv

//--- source/adc_display_pkg.sv
package adc_display_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ADC and DRP
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the conversion result sits in the upper 12 bits of the 16-bit DRP word.
    localparam int CODE_WIDTH     = 12;
    localparam int DRP_DATA_WIDTH = 16;
    localparam int DRP_ADDR_WIDTH = 7;

    // status register addresses of auxiliary channels 6, 7, 14 and 15.
    localparam logic [DRP_ADDR_WIDTH-1:0] CHANNEL_ADDR_0 = 7'h16;
    localparam logic [DRP_ADDR_WIDTH-1:0] CHANNEL_ADDR_1 = 7'h17;
    localparam logic [DRP_ADDR_WIDTH-1:0] CHANNEL_ADDR_2 = 7'h1e;
    localparam logic [DRP_ADDR_WIDTH-1:0] CHANNEL_ADDR_3 = 7'h1f;

    // codes strictly above this value are treated as overrange.
    localparam logic [CODE_WIDTH-1:0] OVERRANGE_CODE = 12'hffd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // display
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DIGIT_COUNT   = 4;
    localparam int DISPLAY_WIDTH = 4 * DIGIT_COUNT;

    // a digit holding this code lights only segment g.
    localparam logic [3:0]               DIGIT_DASH = 4'ha;
    localparam logic [DISPLAY_WIDTH-1:0] DASH_WORD  = {DIGIT_COUNT{DIGIT_DASH}};

    // the converter shifts once per bit of the code.
    localparam int BCD_STEPS        = CODE_WIDTH;
    localparam int STEP_COUNT_WIDTH = $clog2(BCD_STEPS + 1);
    localparam int SHIFT_WIDTH      = DISPLAY_WIDTH + CODE_WIDTH;

    // each digit stays lit for 2^(SCAN_BITS-2) cycles.
    localparam int SCAN_BITS = 16;

    // a board frame lasts 100 ms at 100 MHz.
    localparam int DEFAULT_FRAME_CYCLES = 10_000_000;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FRAME_WAIT,
        ST_CONVERT
    } control_state_e;

endpackage

//--- source/adc_display_top.sv
`timescale 1ns/1ps

module adc_display_top #(
    parameter int frame_cycles = adc_display_pkg::DEFAULT_FRAME_CYCLES
) (
    input  logic        clk100mhz,
    input  logic        reset,
    input  logic [1:0]  sw,
    input  logic        eoc,
    input  logic        drdy,
    input  logic [15:0] drp_data,
    output logic        den,
    output logic [6:0]  daddr,
    output logic [3:0]  an,
    output logic [6:0]  seg,
    output logic        dp,
    output logic [15:0] sseg_data,
    output logic        sseg_update
);

    // latest sample from the DRP side.
    logic [11:0] sample_code;
    logic        sample_valid;

    // converter handshake.
    logic        bcd_start;
    logic [11:0] bin_code;
    logic        bcd_done;
    logic [15:0] bcd_digits;

    drp_reader drp_reader0 (
        .clk100mhz    (clk100mhz),
        .reset        (reset),
        .sw           (sw),
        .eoc          (eoc),
        .drdy         (drdy),
        .drp_data     (drp_data),
        .den          (den),
        .daddr        (daddr),
        .sample_code  (sample_code),
        .sample_valid (sample_valid)
    );

    display_control #(
        .frame_cycles (frame_cycles)
    ) display_control0 (
        .clk100mhz    (clk100mhz),
        .reset        (reset),
        .sample_code  (sample_code),
        .sample_valid (sample_valid),
        .bcd_done     (bcd_done),
        .bcd_digits   (bcd_digits),
        .bcd_start    (bcd_start),
        .bin_code     (bin_code),
        .sseg_data    (sseg_data),
        .sseg_update  (sseg_update)
    );

    bin_to_bcd bin_to_bcd0 (
        .clk100mhz  (clk100mhz),
        .reset      (reset),
        .bcd_start  (bcd_start),
        .bin_code   (bin_code),
        .bcd_done   (bcd_done),
        .bcd_digits (bcd_digits)
    );

    // the scanner shows the same word that leaves the chip.
    seg_scan seg_scan0 (
        .clk100mhz (clk100mhz),
        .reset     (reset),
        .sseg_data (sseg_data),
        .an        (an),
        .seg       (seg),
        .dp        (dp)
    );

endmodule

//--- source/bin_to_bcd.sv
`timescale 1ns/1ps

module bin_to_bcd (
    input  logic                                      clk100mhz,
    input  logic                                      reset,
    input  logic                                      bcd_start,
    input  logic [adc_display_pkg::CODE_WIDTH-1:0]    bin_code,
    output logic                                      bcd_done,
    output logic [adc_display_pkg::DISPLAY_WIDTH-1:0] bcd_digits
);

    // the bcd digits sit in the upper part and the remaining binary bits in the lower part.
    logic [adc_display_pkg::SHIFT_WIDTH-1:0]      shift_reg;
    logic [adc_display_pkg::STEP_COUNT_WIDTH-1:0] step_count;
    logic                                         busy;

    // one double-dabble step corrects each digit and then shifts the whole word.
    function automatic logic [adc_display_pkg::SHIFT_WIDTH-1:0] dabble_step(
        input logic [adc_display_pkg::SHIFT_WIDTH-1:0] value
    );
        logic [adc_display_pkg::SHIFT_WIDTH-1:0] adjusted;
        adjusted = value;
        for (int i = 0; i < adc_display_pkg::DIGIT_COUNT; i++) begin
            if (adjusted[adc_display_pkg::CODE_WIDTH + 4*i +: 4] >= 4'd5) begin
                adjusted[adc_display_pkg::CODE_WIDTH + 4*i +: 4] =
                    adjusted[adc_display_pkg::CODE_WIDTH + 4*i +: 4] + 4'd3;
            end
        end
        return adjusted << 1;
    endfunction

    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            busy       <= 1'b0;
            bcd_done   <= 1'b0;
            step_count <= '0;
        end else begin
            bcd_done <= 1'b0;
            if (bcd_start) begin
                busy       <= 1'b1;
                step_count <= '0;
            end else if (busy) begin
                step_count <= step_count + 1'b1;
                if (step_count == adc_display_pkg::STEP_COUNT_WIDTH'(
                                      adc_display_pkg::BCD_STEPS - 1)) begin
                    busy     <= 1'b0;
                    bcd_done <= 1'b1;
                end
            end
        end
    end

    // the shift register loads the code on start and takes one step per busy cycle.
    always_ff @(posedge clk100mhz) begin
        if (bcd_start) begin
            shift_reg <= {{adc_display_pkg::DISPLAY_WIDTH{1'b0}}, bin_code};
        end else if (busy) begin
            shift_reg <= dabble_step(shift_reg);
        end
    end

    // after the last shift every binary bit has moved into the digit field.
    assign bcd_digits = shift_reg[adc_display_pkg::SHIFT_WIDTH-1 -:
                                  adc_display_pkg::DISPLAY_WIDTH];

endmodule

//--- source/display_control.sv
`timescale 1ns/1ps

module display_control #(
    parameter int frame_cycles = adc_display_pkg::DEFAULT_FRAME_CYCLES
) (
    input  logic                                      clk100mhz,
    input  logic                                      reset,
    input  logic [adc_display_pkg::CODE_WIDTH-1:0]    sample_code,
    input  logic                                      sample_valid,
    input  logic                                      bcd_done,
    input  logic [adc_display_pkg::DISPLAY_WIDTH-1:0] bcd_digits,
    output logic                                      bcd_start,
    output logic [adc_display_pkg::CODE_WIDTH-1:0]    bin_code,
    output logic [adc_display_pkg::DISPLAY_WIDTH-1:0] sseg_data,
    output logic                                      sseg_update
);

    adc_display_pkg::control_state_e state;

    // counts the cycles spent in ST_FRAME_WAIT and saturates at the frame end.
    logic [31:0] frame_count;
    logic        frame_end;

    assign frame_end = (frame_count >= 32'(frame_cycles - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            state       <= adc_display_pkg::ST_IDLE;
            frame_count <= '0;
            bcd_start   <= 1'b0;
            sseg_data   <= '0;
            sseg_update <= 1'b0;
        end else begin
            bcd_start   <= 1'b0;
            sseg_update <= 1'b0;
            case (state)
                adc_display_pkg::ST_IDLE: begin
                    frame_count <= '0;
                    state       <= adc_display_pkg::ST_FRAME_WAIT;
                end
                adc_display_pkg::ST_FRAME_WAIT: begin
                    if (!frame_end) begin
                        frame_count <= frame_count + 32'd1;
                    end else if (sample_valid) begin
                        // an overrange code bypasses the converter.
                        if (sample_code > adc_display_pkg::OVERRANGE_CODE) begin
                            sseg_data   <= adc_display_pkg::DASH_WORD;
                            sseg_update <= 1'b1;
                            state       <= adc_display_pkg::ST_IDLE;
                        end else begin
                            bcd_start <= 1'b1;
                            state     <= adc_display_pkg::ST_CONVERT;
                        end
                    end
                end
                adc_display_pkg::ST_CONVERT: begin
                    if (bcd_done) begin
                        sseg_data   <= bcd_digits;
                        sseg_update <= 1'b1;
                        state       <= adc_display_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= adc_display_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // the code is captured together with the start pulse and then held
    // for the whole conversion, whatever the DRP side does meanwhile.
    always_ff @(posedge clk100mhz) begin
        if (state == adc_display_pkg::ST_FRAME_WAIT && frame_end && sample_valid) begin
            bin_code <= sample_code;
        end
    end

endmodule

//--- source/drp_reader.sv
`timescale 1ns/1ps

module drp_reader (
    input  logic                                       clk100mhz,
    input  logic                                       reset,
    input  logic [1:0]                                 sw,
    input  logic                                       eoc,
    input  logic                                       drdy,
    input  logic [adc_display_pkg::DRP_DATA_WIDTH-1:0] drp_data,
    output logic                                       den,
    output logic [adc_display_pkg::DRP_ADDR_WIDTH-1:0] daddr,
    output logic [adc_display_pkg::CODE_WIDTH-1:0]     sample_code,
    output logic                                       sample_valid
);

    // high from the den pulse until the matching drdy comes back.
    logic busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel address
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            daddr <= adc_display_pkg::CHANNEL_ADDR_0;
        end else begin
            case (sw)
                2'd0:    daddr <= adc_display_pkg::CHANNEL_ADDR_0;
                2'd1:    daddr <= adc_display_pkg::CHANNEL_ADDR_1;
                2'd2:    daddr <= adc_display_pkg::CHANNEL_ADDR_2;
                default: daddr <= adc_display_pkg::CHANNEL_ADDR_3;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DRP read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            den          <= 1'b0;
            busy         <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            den <= 1'b0;
            if (busy) begin
                // an eoc seen here is dropped; the next one triggers a fresh read.
                if (drdy) begin
                    busy         <= 1'b0;
                    sample_valid <= 1'b1;
                end
            end else if (eoc) begin
                den  <= 1'b1;
                busy <= 1'b1;
            end
        end
    end

    // the low four bits of the status word are not part of the result.
    always_ff @(posedge clk100mhz) begin
        if (busy && drdy) begin
            sample_code <= drp_data[adc_display_pkg::DRP_DATA_WIDTH-1 -:
                                    adc_display_pkg::CODE_WIDTH];
        end
    end

endmodule

//--- source/seg_scan.sv
`timescale 1ns/1ps

module seg_scan (
    input  logic                                      clk100mhz,
    input  logic                                      reset,
    input  logic [adc_display_pkg::DISPLAY_WIDTH-1:0] sseg_data,
    output logic [3:0]                                an,
    output logic [6:0]                                seg,
    output logic                                      dp
);

    logic [adc_display_pkg::SCAN_BITS-1:0] refresh_count;
    logic [1:0]                            digit_sel;
    logic [3:0]                            digit_code;

    // segment order is {g, f, e, d, c, b, a}, and a zero lights a segment.
    function automatic logic [6:0] decode_digit(input logic [3:0] code);
        logic [6:0] pattern;
        case (code)
            4'd0:    pattern = 7'b1000000;
            4'd1:    pattern = 7'b1111001;
            4'd2:    pattern = 7'b0100100;
            4'd3:    pattern = 7'b0110000;
            4'd4:    pattern = 7'b0011001;
            4'd5:    pattern = 7'b0010010;
            4'd6:    pattern = 7'b0000010;
            4'd7:    pattern = 7'b1111000;
            4'd8:    pattern = 7'b0000000;
            4'd9:    pattern = 7'b0010000;
            adc_display_pkg::DIGIT_DASH: pattern = 7'b0111111;
            default: pattern = 7'b1111111;
        endcase
        return pattern;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // digit refresh
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            refresh_count <= '0;
        end else begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    // the top two counter bits pick the digit, so each one is lit for a quarter turn.
    always_ff @(posedge clk100mhz) begin
        if (reset) begin
            digit_sel <= 2'd0;
            an        <= 4'b1110;
        end else begin
            digit_sel <= refresh_count[adc_display_pkg::SCAN_BITS-1 -: 2];
            an        <= ~(4'b0001 << refresh_count[adc_display_pkg::SCAN_BITS-1 -: 2]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // segment decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // digit 0 is the rightmost display and the lowest nibble.
    assign digit_code = sseg_data[4*digit_sel +: 4];
    assign seg        = decode_digit(digit_code);

    // the decimal point is not used.
    assign dp = 1'b1;

endmodule

//--- testbench/adc_drp_model.sv
`timescale 1ns/1ps

module adc_drp_model (
    input  logic        clk100mhz,
    input  logic        reset,
    input  logic        den,
    input  logic [6:0]  daddr,
    input  logic [2:0]  rd_delay,
    input  logic [11:0] chan_0,
    input  logic [11:0] chan_1,
    input  logic [11:0] chan_2,
    input  logic [11:0] chan_3,
    output logic        eoc,
    output logic        drdy,
    output logic [15:0] drp_data
);

    localparam int EOC_PERIOD = 50;

    int         eoc_count;
    logic       pending;
    logic [2:0] wait_count;
    logic [6:0] read_addr;

    // status registers of the four auxiliary channels; other addresses read as zero.
    function automatic logic [11:0] channel_value(input logic [6:0] addr);
        case (addr)
            adc_display_pkg::CHANNEL_ADDR_0: return chan_0;
            adc_display_pkg::CHANNEL_ADDR_1: return chan_1;
            adc_display_pkg::CHANNEL_ADDR_2: return chan_2;
            adc_display_pkg::CHANNEL_ADDR_3: return chan_3;
            default:                         return 12'h000;
        endcase
    endfunction

    // outputs change shortly after the rising edge, like the other DUT inputs.
    initial begin
        eoc        = 1'b0;
        drdy       = 1'b0;
        drp_data   = 16'h0000;
        eoc_count  = 0;
        pending    = 1'b0;
        wait_count = 3'd0;
        read_addr  = 7'h00;
        forever begin
            @(posedge clk100mhz);
            #1;
            eoc      = 1'b0;
            drdy     = 1'b0;
            drp_data = 16'h0000;
            if (reset) begin
                eoc_count = 0;
                pending   = 1'b0;
            end else begin
                if (eoc_count == EOC_PERIOD - 1) begin
                    eoc_count = 0;
                    eoc       = 1'b1;
                end else begin
                    eoc_count++;
                end
                // a read answers after the delay the testbench chose at den time.
                if (pending) begin
                    if (wait_count == 3'd0) begin
                        drdy     = 1'b1;
                        drp_data = {channel_value(read_addr), 4'h0};
                        pending  = 1'b0;
                    end else begin
                        wait_count = wait_count - 3'd1;
                    end
                end else if (den) begin
                    pending    = 1'b1;
                    wait_count = rd_delay - 3'd1;
                    read_addr  = daddr;
                end
            end
        end
    end

endmodule

//--- testbench/tb_adc_display.sv
`timescale 1ns/1ps

module tb_adc_display;

    localparam int CLK_PERIOD      = 40;
    localparam int FRAME_CYCLES    = 200;
    localparam int FRAME_ALLOWANCE = 300;
    localparam int WATCHDOG_FRAMES = 40;
    localparam int RANDOM_TESTS    = 6;

    logic        clk100mhz = 1'b0;
    logic        reset;
    logic [1:0]  sw;
    logic [2:0]  rd_delay;
    logic [11:0] chan_value [4];
    logic        eoc;
    logic        drdy;
    logic [15:0] drp_data;
    logic        den;
    logic [6:0]  daddr;
    logic [3:0]  an;
    logic [6:0]  seg;
    logic        dp;
    logic [15:0] sseg_data;
    logic        sseg_update;

    logic [16:0] lfsr_state = 17'd93871;
    logic [1:0]  sw_q;
    logic [3:0]  seen_sw = 4'b0000;
    logic        checks_on = 1'b0;
    int          cycle_count = 0;
    int          last_update_cycle = -1;

    always #(CLK_PERIOD / 2) clk100mhz = ~clk100mhz;

    adc_display_top #(
        .frame_cycles (FRAME_CYCLES)
    ) dut0 (
        .clk100mhz   (clk100mhz),
        .reset       (reset),
        .sw          (sw),
        .eoc         (eoc),
        .drdy        (drdy),
        .drp_data    (drp_data),
        .den         (den),
        .daddr       (daddr),
        .an          (an),
        .seg         (seg),
        .dp          (dp),
        .sseg_data   (sseg_data),
        .sseg_update (sseg_update)
    );

    adc_drp_model adc_model0 (
        .clk100mhz (clk100mhz),
        .reset     (reset),
        .den       (den),
        .daddr     (daddr),
        .rd_delay  (rd_delay),
        .chan_0    (chan_value[0]),
        .chan_1    (chan_value[1]),
        .chan_2    (chan_value[2]),
        .chan_3    (chan_value[3]),
        .eoc       (eoc),
        .drdy      (drdy),
        .drp_data  (drp_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns %s", $time, msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    // 17-bit Fibonacci LFSR with taps 17 and 14 that steps once per random bit.
    function automatic logic lfsr_step();
        logic feedback;
        feedback   = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], feedback};
        return feedback;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_step());
        end
        return value;
    endfunction

    // four decimal digits with the least significant one in the lowest nibble.
    function automatic logic [15:0] decimal_digits(input int code);
        logic [15:0] digits;
        int          rest;
        rest = code;
        for (int i = 0; i < 4; i++) begin
            digits[4*i +: 4] = 4'(rest % 10);
            rest             = rest / 10;
        end
        return digits;
    endfunction

    // active-low segments in the order {g, f, e, d, c, b, a}.
    function automatic logic [6:0] expected_segments(input logic [3:0] code);
        case (code)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            4'ha:    return 7'b0111111;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [6:0] channel_addr(input logic [1:0] sel);
        case (sel)
            2'd0:    return adc_display_pkg::CHANNEL_ADDR_0;
            2'd1:    return adc_display_pkg::CHANNEL_ADDR_1;
            2'd2:    return adc_display_pkg::CHANNEL_ADDR_2;
            default: return adc_display_pkg::CHANNEL_ADDR_3;
        endcase
    endfunction

    function automatic int active_digit(input logic [3:0] anodes);
        int index;
        index = 0;
        for (int i = 0; i < 4; i++) begin
            if (!anodes[i]) begin
                index = i;
            end
        end
        return index;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk100mhz) begin
        cycle_count <= cycle_count + 1;
        sw_q        <= sw;
    end

    assert property (@(posedge clk100mhz) disable iff (reset) den |=> !den)
        else report_error("den stayed high for more than one cycle");

    assert property (@(posedge clk100mhz) disable iff (reset) sseg_update |=> !sseg_update)
        else report_error("sseg_update stayed high for more than one cycle");

    // outputs are settled at the falling edge.
    always @(negedge clk100mhz) begin
        int lit;
        if (checks_on) begin
            lit = active_digit(an);
            assert ($countones(~an) == 1)
                else report_error($sformatf("anodes %04b do not light one digit", an));
            assert (seg == expected_segments(sseg_data[4*lit +: 4]))
                else report_error($sformatf("digit %0d shows seg %07b for data %04h",
                                            lit, seg, sseg_data));
            assert (dp == 1'b1)
                else report_error("decimal point is lit");
            if (den) begin
                assert (daddr == channel_addr(sw_q))
                    else report_error($sformatf("daddr %02h for sw %0d", daddr, sw_q));
                seen_sw[sw_q] = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_update(output logic [15:0] shown);
        int waited;
        waited = 0;
        do begin
            @(posedge clk100mhz);
            #2;
            rd_delay = 3'd2 + 3'(random_bits(2));
            waited++;
            if (waited > FRAME_ALLOWANCE) begin
                abort_run("no display update arrived within one frame allowance");
            end
        end while (!sseg_update);
        if (last_update_cycle >= 0) begin
            assert (cycle_count - last_update_cycle >= FRAME_CYCLES)
                else report_error($sformatf("updates only %0d cycles apart",
                                            cycle_count - last_update_cycle));
        end
        last_update_cycle = cycle_count;
        shown = sseg_data;
    endtask

    // the first update after a change may still carry the old sample.
    task automatic run_test(input logic [1:0] sel, input logic [11:0] code);
        logic [15:0] shown;
        logic [15:0] expected;
        for (int i = 0; i < 4; i++) begin
            chan_value[i] = 12'(random_bits(12));
        end
        sw              = sel;
        chan_value[sel] = code;
        if (code > adc_display_pkg::OVERRANGE_CODE) begin
            expected = adc_display_pkg::DASH_WORD;
        end else begin
            expected = decimal_digits(int'(code));
        end
        wait_update(shown);
        repeat (2) begin
            wait_update(shown);
            assert (shown == expected)
                else report_error($sformatf("channel %0d code %03h shows %04h, expected %04h",
                                            sel, code, shown, expected));
        end
    endtask

    initial begin
        logic [11:0] forced_codes [7];
        logic [1:0]  sel;
        logic [11:0] code;
        forced_codes = '{12'd0, 12'd9, 12'd999, 12'd1000, 12'hffd, 12'hffe, 12'hfff};
        reset    = 1'b1;
        sw       = 2'd0;
        rd_delay = 3'd2;
        for (int i = 0; i < 4; i++) begin
            chan_value[i] = 12'h000;
        end
        repeat (16) @(posedge clk100mhz);
        #2;
        reset = 1'b0;
        assert (den == 1'b0 && sseg_update == 1'b0 && sseg_data == 16'h0000)
            else report_error("outputs not cleared by reset");
        checks_on = 1'b1;
        for (int i = 0; i < 7; i++) begin
            run_test(2'(i % 4), forced_codes[i]);
        end
        for (int i = 0; i < RANDOM_TESTS; i++) begin
            sel  = 2'(random_bits(2));
            code = 12'(random_bits(12));
            run_test(sel, code);
        end
        assert (seen_sw == 4'b1111)
            else report_error($sformatf("switch values seen at den %04b", seen_sw));
        $display("sim passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_FRAMES * FRAME_ALLOWANCE * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

endmodule
